//--- flist.f
source/rv_pkg.sv
source/rv_alu.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_exec.sv
source/rv_lsu.sv
source/rv_core.sv
tb/tb_wb_memory.sv
tb/tb_rv_core.sv

//--- run.sh
#!/bin/sh
# Build and run with Verilator; the log decides pass or fail.
verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_core \
	-f flist.f -o sim_rv_core > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_rv_core > sim.log 2>&1 ; cat sim.log
grep -q "ERRORS FOUND" sim.log && exit 1 || grep -q "NO ERRORS" sim.log || exit 1
exit 0

//--- tb/tb_rv_core.sv
`timescale 1ns/1ns

module tb_rv_core;

	logic        clock;
	logic        reset;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [31:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [3:0]  wb_sel;
	logic [31:0] wb_dat_r;
	logic        wb_ack;
	logic        halted;

	logic [31:0] exp_fetch [$];
	logic [31:0] exp_adr [$];
	logic [31:0] exp_dat [$];
	logic [3:0]  exp_sel [$];
	int          fetch_idx;
	int          st_idx;
	logic        next_is_data;
	logic [31:0] load_pa;
	int          err_bus;
	int          err_store;
	int          err_fetch;
	int          err_halt;
	int          err_run;

	localparam int PROG_LEN = 48;

	rv_core u_rv_core (
		.clock    (clock),
		.reset    (reset),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_sel   (wb_sel),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.halted   (halted)
	);

	tb_wb_memory u_mem (
		.clock (clock),
		.reset (reset),
		.cyc   (wb_cyc),
		.stb   (wb_stb),
		.we    (wb_we),
		.adr   (wb_adr),
		.dat_w (wb_dat_w),
		.sel   (wb_sel),
		.dat_r (wb_dat_r),
		.ack   (wb_ack)
	);

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, rv_pkg::OP_REG};
	endfunction

	function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm[11:0], rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [31:0] imm, input logic [4:0] rs2,
			input logic [2:0] f3);
		return {imm[11:5], rs2, 5'd10, f3, imm[4:0], rv_pkg::OP_STORE};
	endfunction

	function automatic logic [31:0] enc_b(input logic [31:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OP_BRANCH};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] enc_j(input logic [31:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
	endfunction

	task automatic emit(input logic [31:0] word);
		u_mem.mem[load_pa[9:2]] = word;
		load_pa = load_pa + 32'd4;
	endtask

	task automatic expect_store(input logic [31:0] adr, input logic [31:0] dat,
			input logic [3:0] sel);
		exp_adr.push_back(adr);
		exp_dat.push_back(dat);
		exp_sel.push_back(sel);
	endtask

	// Test program of ALU results and memory widths, then branches and jumps.
	task automatic load_program();
		load_pa = 32'h0;
		emit(enc_i(32'd512, 5'd0, rv_pkg::F3_ADDSUB, 5'd10, rv_pkg::OP_IMM));
		emit(enc_i(32'd100, 5'd0, rv_pkg::F3_ADDSUB, 5'd1, rv_pkg::OP_IMM));
		emit(enc_i(-32'sd7, 5'd0, rv_pkg::F3_ADDSUB, 5'd2, rv_pkg::OP_IMM));
		emit(enc_r(7'd0, 5'd2, 5'd1, rv_pkg::F3_ADDSUB, 5'd3));
		emit(enc_s(32'd0, 5'd3, rv_pkg::F3_W));
		emit(enc_r(rv_pkg::F7_ALT, 5'd1, 5'd2, rv_pkg::F3_ADDSUB, 5'd4));
		emit(enc_s(32'd4, 5'd4, rv_pkg::F3_W));
		emit(enc_i(32'h401, 5'd2, rv_pkg::F3_SR, 5'd5, rv_pkg::OP_IMM));
		emit(enc_s(32'd8, 5'd5, rv_pkg::F3_W));
		emit(enc_r(7'd0, 5'd1, 5'd2, rv_pkg::F3_SLT, 5'd6));
		emit(enc_r(7'd0, 5'd1, 5'd2, rv_pkg::F3_SLTU, 5'd7));
		emit(enc_s(32'd12, 5'd6, rv_pkg::F3_W));
		emit(enc_s(32'd16, 5'd7, rv_pkg::F3_W));
		emit(enc_r(7'd0, 5'd1, 5'd2, rv_pkg::F3_SR, 5'd8));
		emit(enc_s(32'd20, 5'd8, rv_pkg::F3_W));
		emit(enc_u(20'h12345, 5'd9, rv_pkg::OP_LUI));
		emit(enc_i(32'h678, 5'd9, rv_pkg::F3_XOR, 5'd9, rv_pkg::OP_IMM));
		emit(enc_s(32'd24, 5'd9, rv_pkg::F3_W));
		emit(enc_u(20'h00001, 5'd11, rv_pkg::OP_AUIPC));
		emit(enc_s(32'd28, 5'd11, rv_pkg::F3_W));
		emit(enc_s(32'd33, 5'd9, rv_pkg::F3_B));
		emit(enc_s(32'd38, 5'd2, rv_pkg::F3_H));
		emit(enc_i(32'd38, 5'd10, rv_pkg::F3_H, 5'd12, rv_pkg::OP_LOAD));
		emit(enc_s(32'd40, 5'd12, rv_pkg::F3_W));
		emit(enc_i(32'd38, 5'd10, rv_pkg::F3_HU, 5'd13, rv_pkg::OP_LOAD));
		emit(enc_s(32'd44, 5'd13, rv_pkg::F3_W));
		emit(enc_i(32'd39, 5'd10, rv_pkg::F3_B, 5'd14, rv_pkg::OP_LOAD));
		emit(enc_s(32'd48, 5'd14, rv_pkg::F3_W));
		emit(enc_i(32'd38, 5'd10, rv_pkg::F3_BU, 5'd15, rv_pkg::OP_LOAD));
		emit(enc_s(32'd52, 5'd15, rv_pkg::F3_W));
		emit(enc_b(32'd8, 5'd2, 5'd1, rv_pkg::F3_BEQ));
		emit(enc_b(32'd8, 5'd1, 5'd2, rv_pkg::F3_BLT));
		emit(enc_i(32'd1, 5'd0, rv_pkg::F3_ADDSUB, 5'd16, rv_pkg::OP_IMM));
		emit(enc_b(32'd8, 5'd1, 5'd2, rv_pkg::F3_BGEU));
		emit(enc_i(32'd2, 5'd0, rv_pkg::F3_ADDSUB, 5'd16, rv_pkg::OP_IMM));
		emit(enc_b(32'd8, 5'd1, 5'd1, rv_pkg::F3_BNE));
		emit(enc_i(32'd5, 5'd16, rv_pkg::F3_ADDSUB, 5'd16, rv_pkg::OP_IMM));
		emit(enc_s(32'd56, 5'd16, rv_pkg::F3_W));
		emit(enc_j(32'd12, 5'd17));
		emit(enc_i(32'd9, 5'd0, rv_pkg::F3_ADDSUB, 5'd16, rv_pkg::OP_IMM));
		emit(enc_i(32'd9, 5'd0, rv_pkg::F3_ADDSUB, 5'd16, rv_pkg::OP_IMM));
		emit(enc_s(32'd60, 5'd17, rv_pkg::F3_W));
		emit(enc_i(32'hB4, 5'd0, rv_pkg::F3_ADDSUB, 5'd18, rv_pkg::OP_IMM));
		emit(enc_i(32'd5, 5'd18, 3'b000, 5'd19, rv_pkg::OP_JALR));
		emit(enc_i(32'd9, 5'd0, rv_pkg::F3_ADDSUB, 5'd16, rv_pkg::OP_IMM));
		emit(enc_i(32'd9, 5'd0, rv_pkg::F3_ADDSUB, 5'd16, rv_pkg::OP_IMM));
		emit(enc_s(32'd64, 5'd19, rv_pkg::F3_W));
		emit(rv_pkg::EBREAK_WORD);
	endtask

	task automatic build_expectations();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] h;
		a = 32'd100;
		b = -32'sd7;
		h = (32'h12345 << 12) ^ 32'h678;
		expect_store(32'h200, a + b, 4'hF);
		expect_store(32'h204, b - a, 4'hF);
		expect_store(32'h208, $signed(b) >>> 1, 4'hF);
		expect_store(32'h20C, {31'b0, $signed(b) < $signed(a)}, 4'hF);
		expect_store(32'h210, {31'b0, b < a}, 4'hF);
		expect_store(32'h214, b >> a[4:0], 4'hF);
		expect_store(32'h218, h, 4'hF);
		expect_store(32'h21C, 32'h48 + 32'h1000, 4'hF);
		// Byte at 0x221 and halfword at 0x226.
		expect_store(32'h220, {4{h[7:0]}}, 4'b0010);
		expect_store(32'h224, {2{b[15:0]}}, 4'b1100);
		expect_store(32'h228, {{16{b[15]}}, b[15:0]}, 4'hF);
		expect_store(32'h22C, {16'b0, b[15:0]}, 4'hF);
		expect_store(32'h230, {{24{b[15]}}, b[15:8]}, 4'hF);
		expect_store(32'h234, {24'b0, b[7:0]}, 4'hF);
		expect_store(32'h238, 32'd5, 4'hF);
		expect_store(32'h23C, 32'h98 + 32'd4, 4'hF);
		expect_store(32'h240, 32'hAC + 32'd4, 4'hF);
		for (int p = 0; p <= 32'h7C; p += 4) begin
			exp_fetch.push_back(p);
		end
		exp_fetch.push_back(32'h84);
		exp_fetch.push_back(32'h8C);
		exp_fetch.push_back(32'h90);
		exp_fetch.push_back(32'h94);
		exp_fetch.push_back(32'h98);
		exp_fetch.push_back(32'hA4);
		exp_fetch.push_back(32'hA8);
		exp_fetch.push_back(32'hAC);
		exp_fetch.push_back(32'hB8);
		exp_fetch.push_back(32'hBC);
	endtask

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// Tells fetches from data accesses by the opcode of the fetched word.
	always @(posedge clock) begin
		if (reset) begin
			fetch_idx    <= 0;
			st_idx       <= 0;
			next_is_data <= 1'b0;
		end else if (wb_stb && wb_ack) begin
			if (wb_we)
				st_idx <= st_idx + 1;
			if (next_is_data) begin
				next_is_data <= 1'b0;
			end else begin
				fetch_idx    <= fetch_idx + 1;
				next_is_data <= (wb_dat_r[6:0] == rv_pkg::OP_LOAD) ||
						(wb_dat_r[6:0] == rv_pkg::OP_STORE);
			end
		end
	end

	a_reset_idle: assert property (@(posedge clock) reset && $past(reset) |->
			!wb_cyc && !wb_stb && !wb_we && !halted)
		else begin
			err_bus++;
			$display("CHECK FAILED wb_cyc=%h wb_stb=%h wb_we=%h halted=%h during reset",
					wb_cyc, wb_stb, wb_we, halted);
		end

	a_first_fetch: assert property (@(posedge clock) $fell(reset) |->
			wb_stb && !wb_we && wb_adr == rv_pkg::RESET_PC)
		else begin
			err_fetch++;
			$display("CHECK FAILED wb_adr=%h expected=%h", wb_adr, rv_pkg::RESET_PC);
		end

	a_hold: assert property (@(posedge clock) disable iff (reset)
			wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we) &&
			$stable(wb_sel) && $stable(wb_dat_w))
		else begin
			err_bus++;
			$display("Bus request changed before ack at adr %h", wb_adr);
		end

	a_drop: assert property (@(posedge clock) disable iff (reset) wb_ack |=> !wb_stb)
		else begin
			err_bus++;
			$display("CHECK FAILED wb_stb=%h in the cycle after ack", wb_stb);
		end

	a_st_adr: assert property (@(posedge clock) disable iff (reset)
			wb_stb && wb_we && wb_ack |-> wb_adr == exp_adr[st_idx])
		else begin
			err_store++;
			$display("CHECK FAILED wb_adr=%h expected=%h", wb_adr, exp_adr[st_idx]);
		end

	a_st_dat: assert property (@(posedge clock) disable iff (reset)
			wb_stb && wb_we && wb_ack |-> wb_dat_w == exp_dat[st_idx])
		else begin
			err_store++;
			$display("CHECK FAILED wb_dat_w=%h expected=%h", wb_dat_w, exp_dat[st_idx]);
		end

	a_st_sel: assert property (@(posedge clock) disable iff (reset)
			wb_stb && wb_we && wb_ack |-> wb_sel == exp_sel[st_idx])
		else begin
			err_store++;
			$display("CHECK FAILED wb_sel=%h expected=%h", wb_sel, exp_sel[st_idx]);
		end

	a_fetch: assert property (@(posedge clock) disable iff (reset)
			wb_stb && wb_ack && !next_is_data |-> wb_adr == exp_fetch[fetch_idx])
		else begin
			err_fetch++;
			$display("CHECK FAILED wb_adr=%h expected=%h", wb_adr, exp_fetch[fetch_idx]);
		end

	a_ebreak: assert property (@(posedge clock) disable iff (reset)
			wb_stb && wb_ack && !next_is_data && wb_dat_r == rv_pkg::EBREAK_WORD
			|=> ##1 halted)
		else begin
			err_halt++;
			$display("CHECK FAILED halted=%h two cycles after EBREAK fetch", halted);
		end

	a_stay_halted: assert property (@(posedge clock) disable iff (reset)
			halted |=> halted && !wb_cyc)
		else begin
			err_halt++;
			$display("CHECK FAILED halted=%h wb_cyc=%h after halt", halted, wb_cyc);
		end

	// Watchdog sized for the worst case of wait states.
	initial begin
		repeat (40 * PROG_LEN * 4) @(posedge clock);
		$display("Timeout, the core did not halt");
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		int total;
		reset     = 1'b1;
		err_bus   = 0;
		err_store = 0;
		err_fetch = 0;
		err_halt  = 0;
		err_run   = 0;
		#1;
		load_program();
		build_expectations();
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		while (!halted) @(posedge clock);
		repeat (20) @(posedge clock);
		if (st_idx != exp_adr.size()) begin
			err_run++;
			$display("Saw %0d stores, the program makes %0d", st_idx, exp_adr.size());
		end
		if (fetch_idx != exp_fetch.size()) begin
			err_run++;
			$display("Saw %0d fetches, the program makes %0d", fetch_idx, exp_fetch.size());
		end
		total = err_bus + err_store + err_fetch + err_halt + err_run;
		$display("errors: bus %0d store %0d fetch %0d halt %0d run %0d total %0d",
				err_bus, err_store, err_fetch, err_halt, err_run, total);
		if (total == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- tb/tb_wb_memory.sv
`timescale 1ns/1ns

module tb_wb_memory (
	input  logic        clock,
	input  logic        reset,
	input  logic        cyc,
	input  logic        stb,
	input  logic        we,
	input  logic [31:0] adr,
	input  logic [31:0] dat_w,
	input  logic [3:0]  sel,
	output logic [31:0] dat_r,
	output logic        ack
);

	logic [31:0] mem [0:255];
	logic [31:0] lfsr;
	logic [31:0] lfsr_one;
	logic [31:0] lfsr_two;
	logic        busy;
	logic [1:0]  wait_left;

	// Fibonacci LFSR with taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	assign lfsr_one = lfsr_step(lfsr);
	assign lfsr_two = lfsr_step(lfsr_one);

	initial begin
		lfsr = 32'h301793cf;
		for (int i = 0; i < 256; i++) begin
			mem[i] = 32'h5A5A_0000 ^ (i * 4);
		end
	end

	always @(posedge clock) begin
		if (reset) begin
			ack  <= 1'b0;
			busy <= 1'b0;
		end else if (ack) begin
			ack  <= 1'b0;
			busy <= 1'b0;
		end else if (cyc && stb) begin
			if (!busy) begin
				// Two bits per access give 0 to 3 extra wait states.
				busy      <= 1'b1;
				wait_left <= {lfsr_one[0], lfsr_two[0]};
				lfsr      <= lfsr_two;
			end else if (wait_left == 2'd0) begin
				ack   <= 1'b1;
				dat_r <= mem[adr[9:2]];
				if (we) begin
					for (int b = 0; b < 4; b++) begin
						if (sel[b])
							mem[adr[9:2]][b*8 +: 8] <= dat_w[b*8 +: 8];
					end
				end
			end else begin
				wait_left <= wait_left - 2'd1;
			end
		end
	end

endmodule

//--- source/rv_core.sv
`timescale 1ns/1ns

module rv_core (
	input  logic        clock,
	input  logic        reset,
	output logic        wb_cyc,
	output logic        wb_stb,
	output logic        wb_we,
	output logic [31:0] wb_adr,
	output logic [31:0] wb_dat_w,
	output logic [3:0]  wb_sel,
	input  logic [31:0] wb_dat_r,
	input  logic        wb_ack,
	output logic        halted
);

	logic [1:0]        state;
	logic [31:0]       pc;
	rv_pkg::rv_instr_t ir;
	logic              bus_gap;

	logic [6:0]  opcode;
	logic [4:0]  rd;
	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic [2:0]  func3;
	logic [6:0]  func7;
	logic [31:0] imm;
	logic        is_ebreak;
	logic [31:0] rs1_val;
	logic [31:0] rs2_val;
	logic        writes_rd;
	logic [31:0] wb_value;
	logic        mem_req;
	logic        mem_we;
	logic [31:0] mem_addr;
	logic [31:0] store_value;
	logic [31:0] next_pc;
	logic [3:0]  lsu_sel;
	logic [31:0] lane_data;
	logic [31:0] load_data;

	logic in_fetch;
	logic in_exec;
	logic in_mem;
	logic fetch_ack;
	logic commit;

	assign in_fetch  = (state == rv_pkg::ST_FETCH);
	assign in_exec   = (state == rv_pkg::ST_EXECUTE);
	assign in_mem    = (state == rv_pkg::ST_MEMORY);
	assign fetch_ack = in_fetch && !bus_gap && wb_ack;

	// One bus, shared by fetch and data accesses.
	assign wb_cyc   = !reset && ((in_fetch && !bus_gap) || in_mem);
	assign wb_stb   = wb_cyc;
	assign wb_we    = in_mem && mem_we;
	assign wb_adr   = in_mem ? {mem_addr[31:2], 2'b00} : pc;
	assign wb_sel   = in_mem ? lsu_sel : 4'b1111;
	assign wb_dat_w = in_mem ? lane_data : 32'b0;
	assign halted   = (state == rv_pkg::ST_HALT);

	assign commit = (in_exec && !mem_req && !is_ebreak) || (in_mem && wb_ack);

	always_ff @(posedge clock) begin
		if (reset) begin
			state   <= rv_pkg::ST_FETCH;
			pc      <= rv_pkg::RESET_PC;
			bus_gap <= 1'b0;
		end else begin
			bus_gap <= 1'b0;
			case (state)
				rv_pkg::ST_FETCH:
					if (fetch_ack)
						state <= rv_pkg::ST_EXECUTE;
				rv_pkg::ST_EXECUTE:
					if (is_ebreak)
						state <= rv_pkg::ST_HALT;
					else if (mem_req)
						state <= rv_pkg::ST_MEMORY;
					else
						state <= rv_pkg::ST_FETCH;
				rv_pkg::ST_MEMORY:
					if (wb_ack) begin
						state   <= rv_pkg::ST_FETCH;
						// Idle cycle before the next fetch.
						bus_gap <= 1'b1;
					end
				default:
					state <= rv_pkg::ST_HALT;
			endcase
			if (commit)
				pc <= next_pc;
		end
	end

	always_ff @(posedge clock) begin
		if (fetch_ack)
			ir <= wb_dat_r;
	end

	rv_decoder u_rv_decoder (
		.instr     (ir),
		.opcode    (opcode),
		.rd        (rd),
		.rs1       (rs1),
		.rs2       (rs2),
		.func3     (func3),
		.func7     (func7),
		.imm       (imm),
		.is_ebreak (is_ebreak)
	);

	rv_regfile u_rv_regfile (
		.clock  (clock),
		.reset  (reset),
		.we     (commit && writes_rd),
		.waddr  (rd),
		.wdata  (wb_value),
		.raddr1 (rs1),
		.raddr2 (rs2),
		.rdata1 (rs1_val),
		.rdata2 (rs2_val)
	);

	rv_exec u_rv_exec (
		.pc          (pc),
		.imm         (imm),
		.opcode      (opcode),
		.rd          (rd),
		.func3       (func3),
		.func7       (func7),
		.rs1_val     (rs1_val),
		.rs2_val     (rs2_val),
		.load_data   (load_data),
		.writes_rd   (writes_rd),
		.wb_value    (wb_value),
		.mem_req     (mem_req),
		.mem_we      (mem_we),
		.mem_addr    (mem_addr),
		.store_value (store_value),
		.next_pc     (next_pc)
	);

	rv_lsu u_rv_lsu (
		.mem_addr    (mem_addr),
		.func3       (func3),
		.store_value (store_value),
		.rdata       (wb_dat_r),
		.sel         (lsu_sel),
		.lane_data   (lane_data),
		.load_data   (load_data)
	);

endmodule

//--- source/rv_lsu.sv
`timescale 1ns/1ns

module rv_lsu (
	input  logic [31:0] mem_addr,
	input  logic [2:0]  func3,
	input  logic [31:0] store_value,
	input  logic [31:0] rdata,
	output logic [3:0]  sel,
	output logic [31:0] lane_data,
	output logic [31:0] load_data
);

	logic [31:0] shifted;

	// Lanes follow the low address bits.
	always_comb begin
		case (func3)
			rv_pkg::F3_B,
			rv_pkg::F3_BU: begin
				sel       = 4'b0001 << mem_addr[1:0];
				lane_data = {4{store_value[7:0]}};
			end
			rv_pkg::F3_H,
			rv_pkg::F3_HU: begin
				sel       = mem_addr[1] ? 4'b1100 : 4'b0011;
				lane_data = {2{store_value[15:0]}};
			end
			default: begin
				sel       = 4'b1111;
				lane_data = store_value;
			end
		endcase
	end

	// Bring the addressed lane down to bit 0.
	assign shifted = rdata >> {mem_addr[1:0], 3'b000};

	always_comb begin
		case (func3)
			rv_pkg::F3_B:
				load_data = {{24{shifted[7]}}, shifted[7:0]};
			rv_pkg::F3_BU:
				load_data = {24'b0, shifted[7:0]};
			rv_pkg::F3_H:
				load_data = {{16{shifted[15]}}, shifted[15:0]};
			rv_pkg::F3_HU:
				load_data = {16'b0, shifted[15:0]};
			default:
				load_data = rdata;
		endcase
	end

endmodule

//--- source/rv_exec.sv
`timescale 1ns/1ns

module rv_exec (
	input  logic [31:0] pc,
	input  logic [31:0] imm,
	input  logic [6:0]  opcode,
	input  logic [4:0]  rd,
	input  logic [2:0]  func3,
	input  logic [6:0]  func7,
	input  logic [31:0] rs1_val,
	input  logic [31:0] rs2_val,
	input  logic [31:0] load_data,
	output logic        writes_rd,
	output logic [31:0] wb_value,
	output logic        mem_req,
	output logic        mem_we,
	output logic [31:0] mem_addr,
	output logic [31:0] store_value,
	output logic [31:0] next_pc
);

	logic [31:0]     snpc;
	logic [31:0]     alu_a;
	logic [31:0]     alu_b;
	logic [31:0]     alu_res;
	rv_pkg::alu_op_t alu_op;
	logic            alt;
	logic            taken;
	logic            is_arith;

	assign snpc     = pc + 32'd4;
	assign alt      = (func7 == rv_pkg::F7_ALT);
	assign is_arith = (opcode == rv_pkg::OP_REG) || (opcode == rv_pkg::OP_IMM);

	// Operand select, keyed on opcode.
	always_comb begin
		alu_a = rs1_val;
		alu_b = imm;
		case (opcode)
			rv_pkg::OP_REG:   alu_b = rs2_val;
			rv_pkg::OP_LUI:   alu_a = 32'b0;
			rv_pkg::OP_AUIPC: alu_a = pc;
			rv_pkg::OP_JAL,
			rv_pkg::OP_JALR: begin
				alu_a = snpc;
				alu_b = 32'b0;
			end
			default: ;
		endcase
	end

	// Addresses and links all use ADD.
	always_comb begin
		alu_op = rv_pkg::ADD;
		if (is_arith) begin
			case (func3)
				rv_pkg::F3_ADDSUB:
					alu_op = (opcode == rv_pkg::OP_REG && alt) ? rv_pkg::SUB : rv_pkg::ADD;
				rv_pkg::F3_SLL:  alu_op = rv_pkg::SLL;
				rv_pkg::F3_SLT:  alu_op = rv_pkg::SLT;
				rv_pkg::F3_SLTU: alu_op = rv_pkg::SLTU;
				rv_pkg::F3_XOR:  alu_op = rv_pkg::XOR;
				rv_pkg::F3_SR:   alu_op = alt ? rv_pkg::SRA : rv_pkg::SRL;
				rv_pkg::F3_OR:   alu_op = rv_pkg::OR;
				default:         alu_op = rv_pkg::AND;
			endcase
		end
	end

	rv_alu u_rv_alu (
		.a      (alu_a),
		.b      (alu_b),
		.op     (alu_op),
		.result (alu_res)
	);

	always_comb begin
		case (func3)
			rv_pkg::F3_BEQ:  taken = (rs1_val == rs2_val);
			rv_pkg::F3_BNE:  taken = (rs1_val != rs2_val);
			rv_pkg::F3_BLT:  taken = ($signed(rs1_val) < $signed(rs2_val));
			rv_pkg::F3_BGE:  taken = ($signed(rs1_val) >= $signed(rs2_val));
			rv_pkg::F3_BLTU: taken = (rs1_val < rs2_val);
			rv_pkg::F3_BGEU: taken = (rs1_val >= rs2_val);
			default:         taken = 1'b0;
		endcase
	end

	always_comb begin
		next_pc = snpc;
		if (opcode == rv_pkg::OP_JAL || (opcode == rv_pkg::OP_BRANCH && taken))
			next_pc = pc + imm;
		else if (opcode == rv_pkg::OP_JALR)
			next_pc = (rs1_val + imm) & ~32'd1;
	end

	assign mem_req     = (opcode == rv_pkg::OP_LOAD) || (opcode == rv_pkg::OP_STORE);
	assign mem_we      = (opcode == rv_pkg::OP_STORE);
	assign mem_addr    = alu_res;
	assign store_value = rs2_val;

	assign wb_value = (opcode == rv_pkg::OP_LOAD) ? load_data : alu_res;

	// No write for stores, branches or system ops.
	assign writes_rd = (rd != 5'd0) &&
			(is_arith || opcode == rv_pkg::OP_LOAD ||
			 opcode == rv_pkg::OP_LUI || opcode == rv_pkg::OP_AUIPC ||
			 opcode == rv_pkg::OP_JAL || opcode == rv_pkg::OP_JALR);

endmodule

//--- source/rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile (
	input  logic        clock,
	input  logic        reset,
	input  logic        we,
	input  logic [4:0]  waddr,
	input  logic [31:0] wdata,
	input  logic [4:0]  raddr1,
	input  logic [4:0]  raddr2,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2
);

	logic [31:0] regs [1:31];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= 32'b0;
			end
		end else if (we && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	// x0 is hardwired.
	assign rdata1 = (raddr1 == 5'd0) ? 32'b0 : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? 32'b0 : regs[raddr2];

endmodule

//--- source/rv_decoder.sv
`timescale 1ns/1ns

module rv_decoder (
	input  rv_pkg::rv_instr_t instr,
	output logic [6:0]        opcode,
	output logic [4:0]        rd,
	output logic [4:0]        rs1,
	output logic [4:0]        rs2,
	output logic [2:0]        func3,
	output logic [6:0]        func7,
	output logic [31:0]       imm,
	output logic              is_ebreak
);

	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;

	assign opcode = instr.r_view.opcode;
	assign rd     = instr.r_view.rd;
	assign rs1    = instr.i_view.rs1;
	assign rs2    = instr.s_view.rs2;
	assign func3  = instr.i_view.func3;
	assign func7  = instr.r_view.func7;

	assign is_ebreak = (instr == rv_pkg::EBREAK_WORD);

	assign imm_i = {{20{instr.i_view.imm12[11]}}, instr.i_view.imm12};
	assign imm_s = {{20{instr.s_view.imm_hi[6]}}, instr.s_view.imm_hi, instr.s_view.imm_lo};

	// Branch offset bits are scattered over the S-type immediate fields.
	assign imm_b = {{19{instr.s_view.imm_hi[6]}},
			instr.s_view.imm_hi[6],
			instr.s_view.imm_lo[0],
			instr.s_view.imm_hi[5:0],
			instr.s_view.imm_lo[4:1],
			1'b0};

	assign imm_u = {instr.u_view.imm20, 12'b0};

	// Jump offset, reordered from the upper twenty bits.
	assign imm_j = {{11{instr.u_view.imm20[19]}},
			instr.u_view.imm20[19],
			instr.u_view.imm20[7:0],
			instr.u_view.imm20[8],
			instr.u_view.imm20[18:9],
			1'b0};

	always_comb begin
		case (opcode)
			rv_pkg::OP_STORE:  imm = imm_s;
			rv_pkg::OP_BRANCH: imm = imm_b;
			rv_pkg::OP_LUI,
			rv_pkg::OP_AUIPC:  imm = imm_u;
			rv_pkg::OP_JAL:    imm = imm_j;
			default:           imm = imm_i;
		endcase
	end

endmodule

//--- source/rv_alu.sv
`timescale 1ns/1ns

module rv_alu (
	input  logic [31:0]     a,
	input  logic [31:0]     b,
	input  rv_pkg::alu_op_t op,
	output logic [31:0]     result
);

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (op)
			rv_pkg::ADD:
				result = a + b;
			rv_pkg::SUB:
				result = a - b;
			rv_pkg::SLL:
				result = a << shamt;
			rv_pkg::SLT:
				result = {31'b0, $signed(a) < $signed(b)};
			rv_pkg::SLTU:
				result = {31'b0, a < b};
			rv_pkg::XOR:
				result = a ^ b;
			rv_pkg::SRL:
				result = a >> shamt;
			rv_pkg::SRA:
				result = $signed(a) >>> shamt;
			rv_pkg::OR:
				result = a | b;
			rv_pkg::AND:
				result = a & b;
			default:
				result = 32'b0;
		endcase
	end

endmodule

//--- source/rv_pkg.sv
package rv_pkg;

	// Major opcodes.
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	// Load and store widths.
	localparam logic [2:0] F3_B  = 3'b000;
	localparam logic [2:0] F3_H  = 3'b001;
	localparam logic [2:0] F3_W  = 3'b010;
	localparam logic [2:0] F3_BU = 3'b100;
	localparam logic [2:0] F3_HU = 3'b101;

	// Branch conditions.
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// Integer ALU functions.
	localparam logic [2:0] F3_ADDSUB = 3'b000;
	localparam logic [2:0] F3_SLL    = 3'b001;
	localparam logic [2:0] F3_SLT    = 3'b010;
	localparam logic [2:0] F3_SLTU   = 3'b011;
	localparam logic [2:0] F3_XOR    = 3'b100;
	localparam logic [2:0] F3_SR     = 3'b101;
	localparam logic [2:0] F3_OR     = 3'b110;
	localparam logic [2:0] F3_AND    = 3'b111;

	localparam logic [6:0] F7_ALT = 7'b0100000;

	localparam logic [31:0] RESET_PC    = 32'h0000_0000;
	localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

	// Core controller states.
	localparam logic [1:0] ST_FETCH   = 2'd0;
	localparam logic [1:0] ST_EXECUTE = 2'd1;
	localparam logic [1:0] ST_MEMORY  = 2'd2;
	localparam logic [1:0] ST_HALT    = 2'd3;

	// Bit 3 marks the alternate form, as in func7.
	typedef enum logic [3:0] {
		ADD  = 4'b0000,
		SLL  = 4'b0001,
		SLT  = 4'b0010,
		SLTU = 4'b0011,
		XOR  = 4'b0100,
		SRL  = 4'b0101,
		OR   = 4'b0110,
		AND  = 4'b0111,
		SUB  = 4'b1000,
		SRA  = 4'b1101
	} alu_op_t;

	typedef struct packed {
		logic [6:0] func7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] func3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  func3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	// Also carries the branch immediate.
	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] func3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	// Also carries the jump immediate.
	typedef struct packed {
		logic [19:0] imm20;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef union packed {
		r_fmt_t r_view;
		i_fmt_t i_view;
		s_fmt_t s_view;
		u_fmt_t u_view;
	} rv_instr_t;

endpackage
